/* hw/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // one master request on the 8-bit bus
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [7:0]  dat;
    } wb8_req_t;

    // one slave response
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb8_rsp_t;

    // address windows, upper address bits only
    // 0xFFFFFDxx timer
    localparam logic [23:0] TIMER_PAGE = 24'hFFFFFD;
    // 0xFFFFFExx random number generator
    localparam logic [23:0] PRNG_PAGE  = 24'hFFFFFE;
    // 0xFFFFFFFx LED register
    localparam logic [27:0] LEDS_PAGE  = 28'hFFFFFFF;

    // sprite transparency: top address bits and the dropped colour
    localparam logic [1:0] TRANSP_TAG   = 2'b10;
    localparam logic [7:0] TRANSP_COLOR = 8'hFF;

    // timer register offsets
    localparam logic [1:0] TMR_RELOAD_LO = 2'd0;
    localparam logic [1:0] TMR_RELOAD_HI = 2'd1;
    localparam logic [1:0] TMR_CTRL      = 2'd2;
    localparam logic [1:0] TMR_STATUS    = 2'd3;

    // timer control bits
    localparam int TMR_CTRL_EN_BIT = 0;
    localparam int TMR_CTRL_IE_BIT = 1;

    // prng byte lanes, lsb first; reading the top lane steps the state
    localparam logic [1:0] PRNG_LANE_LAST = 2'd3;

endpackage

`default_nettype wire

/* hw/wb8_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module wb8_decoder import soc_pkg::*; (
    input  wb8_req_t m_req_i,
    output wb8_rsp_t m_rsp_o,
    output wb8_req_t ram_req_o,
    output wb8_req_t timer_req_o,
    output wb8_req_t prng_req_o,
    output wb8_req_t leds_req_o,
    input  wb8_rsp_t ram_rsp_i,
    input  wb8_rsp_t timer_rsp_i,
    input  wb8_rsp_t prng_rsp_i,
    input  wb8_rsp_t leds_rsp_i
);

    logic sel_timer;
    logic sel_prng;
    logic sel_leds;
    logic sel_ram;
    logic transp_drop;

    // window match, ram takes everything else
    assign sel_timer = (m_req_i.adr[31:8] == TIMER_PAGE);
    assign sel_prng  = (m_req_i.adr[31:8] == PRNG_PAGE);
    assign sel_leds  = (m_req_i.adr[31:4] == LEDS_PAGE);
    assign sel_ram   = ~(sel_timer | sel_prng | sel_leds);

    // transparent sprite pixel, write is swallowed but still acked
    assign transp_drop = (m_req_i.adr[31:30] == TRANSP_TAG) &&
                         (m_req_i.dat == TRANSP_COLOR);

    always_comb begin
        timer_req_o     = m_req_i;
        timer_req_o.cyc = m_req_i.cyc & sel_timer;
        timer_req_o.stb = m_req_i.stb & sel_timer;

        prng_req_o      = m_req_i;
        prng_req_o.cyc  = m_req_i.cyc & sel_prng;
        prng_req_o.stb  = m_req_i.stb & sel_prng;

        leds_req_o      = m_req_i;
        leds_req_o.cyc  = m_req_i.cyc & sel_leds;
        leds_req_o.stb  = m_req_i.stb & sel_leds;

        ram_req_o       = m_req_i;
        ram_req_o.cyc   = m_req_i.cyc & sel_ram;
        ram_req_o.stb   = m_req_i.stb & sel_ram;
        ram_req_o.we    = m_req_i.we & ~transp_drop;
    end

    // response back from the selected slave only
    always_comb begin
        if (sel_timer) begin
            m_rsp_o = timer_rsp_i;
        end else if (sel_prng) begin
            m_rsp_o = prng_rsp_i;
        end else if (sel_leds) begin
            m_rsp_o = leds_rsp_i;
        end else begin
            m_rsp_o = ram_rsp_i;
        end
    end

endmodule

`default_nettype wire

/* hw/bram_wb8.sv */
`timescale 1ns/1ps
`default_nettype none

module bram_wb8 import soc_pkg::*; #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  wire      clk,
    input  wire      reset_i,
    input  wb8_req_t req_i,
    output wb8_rsp_t rsp_o
);

    localparam int RAM_DEPTH = 2 ** RAM_ADDR_BITS;

    logic [7:0]               mem [RAM_DEPTH];
    logic [7:0]               rdata_q;
    logic                     ack_q;
    logic                     access;
    logic [RAM_ADDR_BITS-1:0] addr;

    // high address bits alias onto the array
    assign addr   = req_i.adr[RAM_ADDR_BITS-1:0];
    assign access = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // array and read register
    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                mem[addr] <= req_i.dat;
            end
            rdata_q <= mem[addr];
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

/* hw/leds_wb8.sv */
`timescale 1ns/1ps
`default_nettype none

module leds_wb8 import soc_pkg::*; (
    input  wire        clk,
    input  wire        reset_i,
    input  wb8_req_t   req_i,
    output wb8_rsp_t   rsp_o,
    output logic [7:0] leds_o
);

    logic [7:0] leds_q;
    logic       ack_q;
    logic       access;

    // one register, low address bits don't matter
    assign access = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q  <= 1'b0;
            leds_q <= 8'h00;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                leds_q <= req_i.dat;
            end
        end
    end

    assign leds_o    = leds_q;
    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = leds_q;

endmodule

`default_nettype wire

/* hw/timer_wb8.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_wb8 import soc_pkg::*; (
    input  wire      clk,
    input  wire      reset_i,
    input  wb8_req_t req_i,
    output wb8_rsp_t rsp_o,
    output logic     irq_o
);

    logic        ack_q;
    logic [7:0]  rdata_q;
    logic [15:0] reload_q;
    logic [15:0] count_q;
    logic        en_q;
    logic        ie_q;
    logic        flag_q;
    logic        irq_q;
    logic        access;
    logic        wr;
    logic [1:0]  reg_sel;
    logic        start;
    logic        expire;

    assign reg_sel = req_i.adr[1:0];
    assign access  = req_i.cyc & req_i.stb & ~ack_q;
    assign wr      = access & req_i.we;

    // enable write (re)loads the counter on the ack edge
    assign start  = wr && (reg_sel == TMR_CTRL) && req_i.dat[TMR_CTRL_EN_BIT];
    assign expire = en_q && (count_q == 16'd0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q    <= 1'b0;
            reload_q <= 16'h0000;
            count_q  <= 16'h0000;
            en_q     <= 1'b0;
            ie_q     <= 1'b0;
            flag_q   <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            ack_q <= access;
            irq_q <= flag_q & ie_q;

            if (wr && reg_sel == TMR_RELOAD_LO) begin
                reload_q[7:0] <= req_i.dat;
            end
            if (wr && reg_sel == TMR_RELOAD_HI) begin
                reload_q[15:8] <= req_i.dat;
            end
            if (wr && reg_sel == TMR_CTRL) begin
                en_q <= req_i.dat[TMR_CTRL_EN_BIT];
                ie_q <= req_i.dat[TMR_CTRL_IE_BIT];
            end

            // down-counter, reload on zero
            if (start || expire) begin
                count_q <= reload_q;
            end else if (en_q) begin
                count_q <= count_q - 16'd1;
            end

            // a new expiry is not lost to a clear in the same cycle
            if (expire) begin
                flag_q <= 1'b1;
            end else if (wr && reg_sel == TMR_STATUS && req_i.dat[0]) begin
                flag_q <= 1'b0;
            end
        end
    end

    // register readback
    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_sel)
                TMR_RELOAD_LO: rdata_q <= reload_q[7:0];
                TMR_RELOAD_HI: rdata_q <= reload_q[15:8];
                TMR_CTRL:      rdata_q <= {6'b0, ie_q, en_q};
                default:       rdata_q <= {7'b0, flag_q};
            endcase
        end
    end

    assign irq_o     = irq_q;
    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

/* hw/prng_wb8.sv */
`timescale 1ns/1ps
`default_nettype none

module prng_wb8 import soc_pkg::*; (
    input  wire      clk,
    input  wire      reset_i,
    input  wb8_req_t req_i,
    output wb8_rsp_t rsp_o
);

    logic [31:0] state_q;
    logic [7:0]  rdata_q;
    logic        ack_q;
    logic        access;
    logic [1:0]  lane;
    logic [4:0]  lane_lsb;

    // xorshift32, shifts 13 / 17 / 5
    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign lane     = req_i.adr[1:0];
    assign lane_lsb = {lane, 3'b000};
    assign access   = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q   <= 1'b0;
            state_q <= 32'h0000_0001;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                state_q[lane_lsb +: 8] <= req_i.dat;
            end else if (access && lane == PRNG_LANE_LAST) begin
                state_q <= xorshift_step(state_q);
            end
        end
    end

    // byte from before the step
    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= state_q[lane_lsb +: 8];
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

/* hw/soc_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top import soc_pkg::*; #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  wire        clk,
    input  wire        reset_i,
    input  wb8_req_t   bus_i,
    output wb8_rsp_t   bus_o,
    output logic [7:0] leds_o,
    output logic       irq_o
);

    wb8_req_t ram_req;
    wb8_req_t timer_req;
    wb8_req_t prng_req;
    wb8_req_t leds_req;
    wb8_rsp_t ram_rsp;
    wb8_rsp_t timer_rsp;
    wb8_rsp_t prng_rsp;
    wb8_rsp_t leds_rsp;

    wb8_decoder u_decoder (
        .m_req_i     (bus_i),
        .m_rsp_o     (bus_o),
        .ram_req_o   (ram_req),
        .timer_req_o (timer_req),
        .prng_req_o  (prng_req),
        .leds_req_o  (leds_req),
        .ram_rsp_i   (ram_rsp),
        .timer_rsp_i (timer_rsp),
        .prng_rsp_i  (prng_rsp),
        .leds_rsp_i  (leds_rsp)
    );

    // default window
    bram_wb8 #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) u_bram (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (ram_req),
        .rsp_o   (ram_rsp)
    );

    leds_wb8 u_leds (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (leds_req),
        .rsp_o   (leds_rsp),
        .leds_o  (leds_o)
    );

    timer_wb8 u_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (timer_req),
        .rsp_o   (timer_rsp),
        .irq_o   (irq_o)
    );

    prng_wb8 u_prng (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (prng_req),
        .rsp_o   (prng_rsp)
    );

endmodule

`default_nettype wire

/* testbench/soc_bus_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus_checker import soc_pkg::*; (
    input wire      clk,
    input wire      reset_i,
    input wb8_req_t bus_i,
    input wb8_rsp_t bus_o,
    input wire      irq_o
);

    int fail_count = 0;

    // ack only follows a request
    ack_after_stb: assert property (@(posedge clk) disable iff (reset_i)
        $rose(bus_o.ack) |-> $past(bus_i.cyc && bus_i.stb))
        else begin
            $error("ack rose without a strobe");
            fail_count++;
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
        bus_o.ack |=> !bus_o.ack)
        else begin
            $error("ack held for two cycles");
            fail_count++;
        end

    // no slave may stall
    stb_acked_next: assert property (@(posedge clk) disable iff (reset_i)
        (bus_i.cyc && bus_i.stb && !bus_o.ack) |=> bus_o.ack)
        else begin
            $error("strobe not acked in the next cycle");
            fail_count++;
        end

    irq_low_in_reset: assert property (@(posedge clk) reset_i |=> !irq_o)
        else begin
            $error("irq high during reset");
            fail_count++;
        end

    irq_low_after_reset: assert property (@(posedge clk) $fell(reset_i) |=> !irq_o)
        else begin
            $error("irq high right after reset");
            fail_count++;
        end

endmodule

bind soc_bus_top soc_bus_checker u_checker (
    .clk     (clk),
    .reset_i (reset_i),
    .bus_i   (bus_i),
    .bus_o   (bus_o),
    .irq_o   (irq_o)
);

`default_nettype wire

/* testbench/tb_soc_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus import soc_pkg::*; ();

    localparam int          RAM_ADDR_BITS = 10;
    localparam int          TIMER_RELOAD  = 20;
    localparam int          ACK_LIMIT     = 4;
    localparam int          RAM_STEPS     = 12;
    localparam logic [31:0] PRNG_SEED     = 32'h1234_5678;
    localparam logic [31:0] TIMER_BASE    = {TIMER_PAGE, 8'h00};

    // exp holds the read value and leds the led state after the access
    typedef struct packed {
        logic        we;
        logic [31:0] adr;
        logic [7:0]  dat;
        logic [7:0]  exp;
        logic [7:0]  leds;
    } step_t;

    logic        clk;
    logic        reset_i;
    wb8_req_t    bus_i;
    wb8_rsp_t    bus_o;
    logic [7:0]  leds_o;
    logic        irq_o;

    step_t       steps[$];
    logic [7:0]  ram_ref [int];
    logic [7:0]  leds_ref;
    logic [15:0] reload_ref;
    logic [31:0] prng_ref;
    logic [31:0] lcg_state;
    int          cycles = 0;
    int          cycle_limit = 0;

    soc_bus_top #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) uut (
        .clk     (clk),
        .reset_i (reset_i),
        .bus_i   (bus_i),
        .bus_o   (bus_o),
        .leds_o  (leds_o),
        .irq_o   (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            fail_run($sformatf("run did not finish within %0d cycles", cycle_limit));
        end else if (uut.u_checker.fail_count != 0) begin
            fail_run("a bus checker assertion failed");
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] xorshift_ref(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    // appends one access and predicts its result from the address map
    function automatic void add_step(input logic we, input logic [31:0] adr,
                                     input logic [7:0] dat);
        step_t s;
        int    idx;
        s     = '{we: we, adr: adr, dat: dat, exp: 8'h00, leds: 8'h00};
        idx   = int'(adr[RAM_ADDR_BITS-1:0]);
        if (adr[31:8] == TIMER_PAGE) begin
            // only the reload bytes are used here
            if (we) reload_ref[{adr[0], 3'b000} +: 8] = dat;
            s.exp = reload_ref[{adr[0], 3'b000} +: 8];
        end else if (adr[31:8] == PRNG_PAGE) begin
            if (we) begin
                prng_ref[{adr[1:0], 3'b000} +: 8] = dat;
            end else begin
                s.exp = prng_ref[{adr[1:0], 3'b000} +: 8];
                if (adr[1:0] == 2'd3) prng_ref = xorshift_ref(prng_ref);
            end
        end else if (adr[31:4] == LEDS_PAGE) begin
            if (we) leds_ref = dat;
            s.exp = leds_ref;
        end else begin
            // transparent pixel writes never reach the ram
            if (we && !(adr[31:30] == TRANSP_TAG && dat == TRANSP_COLOR)) ram_ref[idx] = dat;
            if (ram_ref.exists(idx)) s.exp = ram_ref[idx];
        end
        s.leds = leds_ref;
        steps.push_back(s);
    endfunction

    // one classic cycle, then one idle cycle
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [7:0] dat,
                              output logic [7:0] rdata);
        int waited;
        waited = 0;
        bus_i  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                fail_run($sformatf("no ack at address %h after %0d cycles", adr, ACK_LIMIT));
            end
        end while (bus_o.ack !== 1'b1);
        rdata     = bus_o.dat;
        bus_i.cyc = 1'b0;
        bus_i.stb = 1'b0;
        bus_i.we  = 1'b0;
        check_value("ack latency", waited, 1);
        @(negedge clk);
    endtask

    // restart the timer masked and read status n cycles after the enable edge
    task automatic timer_status_after(input int n, input logic [7:0] exp_status);
        logic [7:0] rdata;
        bus_access(1'b1, TIMER_BASE + TMR_CTRL, 8'h00, rdata);
        bus_access(1'b1, TIMER_BASE + TMR_STATUS, 8'h01, rdata);
        bus_access(1'b1, TIMER_BASE + TMR_CTRL, 8'h01, rdata);
        // the status read then returns the flag as it stood n cycles after the enable edge
        repeat (n - 1) begin
            check_value("irq_o", irq_o, 1'b0);
            @(negedge clk);
        end
        bus_access(1'b0, TIMER_BASE + TMR_STATUS, 8'h00, rdata);
        check_value($sformatf("timer status after %0d cycles", n), rdata, exp_status);
        check_value("irq_o", irq_o, 1'b0);
    endtask

    initial begin
        logic [7:0]  rdata;
        logic [31:0] a;
        logic [31:0] d;
        reset_i    = 1'b1;
        bus_i      = '0;
        leds_ref   = 8'h00;
        reload_ref = 16'h0000;
        prng_ref   = 32'h0000_0001;
        lcg_state  = 32'h0b4d2b25;

        add_step(1'b0, {LEDS_PAGE, 4'h3}, 8'h00);
        // ram byte at the low address bits of the led window
        add_step(1'b1, 32'h0000_03F0, 8'h96);
        // random ram traffic interleaved with the led register and read back through an alias
        for (int i = 0; i < RAM_STEPS; i++) begin
            a = lcg_next() & ~32'h0010_0000;
            d = lcg_next();
            add_step(1'b1, a, d[7:0]);
            add_step(1'b1, {LEDS_PAGE, 4'(i)}, d[15:8]);
            add_step(1'b0, a ^ (32'h1 << (RAM_ADDR_BITS + i % 6)), 8'h00);
            add_step(1'b0, {LEDS_PAGE, 4'h0}, 8'h00);
        end
        add_step(1'b1, 32'h8000_0100, 8'h3C);
        add_step(1'b1, 32'h8000_0100, TRANSP_COLOR);
        add_step(1'b0, 32'h8000_0100, 8'h00);
        add_step(1'b1, 32'h4000_0200, TRANSP_COLOR);
        add_step(1'b1, 32'h8000_0300, 8'hA5);
        add_step(1'b0, 32'h4000_0200, 8'h00);
        add_step(1'b0, 32'h8000_0300, 8'h00);
        add_step(1'b1, TIMER_BASE + TMR_RELOAD_LO, 8'h34);
        add_step(1'b1, 32'h0000_0204, 8'h77);
        add_step(1'b1, TIMER_BASE + TMR_RELOAD_HI, 8'h12);
        add_step(1'b0, TIMER_BASE + TMR_RELOAD_LO, 8'h00);
        add_step(1'b0, TIMER_BASE + TMR_RELOAD_HI, 8'h00);
        for (int b = 0; b < 4; b++) add_step(1'b1, {PRNG_PAGE, 8'(b)}, PRNG_SEED[b*8 +: 8]);
        for (int g = 0; g < 3; g++) begin
            for (int b = 0; b < 4; b++) add_step(1'b0, {PRNG_PAGE, 8'(b)}, 8'h00);
            add_step(1'b0, 32'h0000_0204, 8'h00);
        end
        // everything written to ram must still be there
        foreach (ram_ref[k]) add_step(1'b0, 32'(k), 8'h00);
        cycle_limit = steps.size() * 4 + 2 * TIMER_RELOAD + 200;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_value("leds_o", leds_o, 8'h00);

        foreach (steps[i]) begin
            bus_access(steps[i].we, steps[i].adr, steps[i].dat, rdata);
            if (!steps[i].we) begin
                check_value($sformatf("bus_o.dat @%h", steps[i].adr), rdata, steps[i].exp);
            end
            check_value("leds_o", leds_o, steps[i].leds);
            check_value("irq_o", irq_o, 1'b0);
        end

        // timer expiry, interrupt unmask and clear
        bus_access(1'b1, TIMER_BASE + TMR_RELOAD_LO, 8'(TIMER_RELOAD), rdata);
        bus_access(1'b1, TIMER_BASE + TMR_RELOAD_HI, 8'h00, rdata);
        timer_status_after(TIMER_RELOAD, 8'h00);
        timer_status_after(TIMER_RELOAD + 1, 8'h01);
        bus_access(1'b1, TIMER_BASE + TMR_CTRL, 8'h03, rdata);
        check_value("irq_o", irq_o, 1'b1);
        bus_access(1'b1, TIMER_BASE + TMR_STATUS, 8'h01, rdata);
        check_value("irq_o", irq_o, 1'b0);
        bus_access(1'b0, TIMER_BASE + TMR_STATUS, 8'h00, rdata);
        check_value("timer status", rdata, 8'h00);
        bus_access(1'b1, TIMER_BASE + TMR_CTRL, 8'h00, rdata);

        if (uut.u_checker.fail_count != 0) begin
            $display("Verification failed");
            $fatal(1, "%0d assertion failures", uut.u_checker.fail_count);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
hw/soc_pkg.sv
hw/wb8_decoder.sv
hw/bram_wb8.sv
hw/leds_wb8.sv
hw/timer_wb8.sv
hw/prng_wb8.sv
hw/soc_bus_top.sv
testbench/soc_bus_checker.sv
testbench/tb_soc_bus.sv

/* Bender.yml */
package:
  name: soc_bus

sources:
  - files:
      - hw/soc_pkg.sv
      - hw/wb8_decoder.sv
      - hw/bram_wb8.sv
      - hw/leds_wb8.sv
      - hw/timer_wb8.sv
      - hw/prng_wb8.sv
      - hw/soc_bus_top.sv
  - target: test
    files:
      - testbench/soc_bus_checker.sv
      - testbench/tb_soc_bus.sv
